//--- arm_isa_pkg.sv
`default_nettype none

package arm_isa_pkg;

        // Condition field in bits 31..28 of every instruction.
        typedef logic [3:0] cond_t;

        localparam cond_t COND_AL = 4'd14;
        localparam cond_t COND_NV = 4'd15;

        // Data processing opcodes, as encoded in bits 24..21.
        typedef enum logic [3:0] {
                OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_SBC, OP_RSC,
                OP_TST, OP_TEQ, OP_CMP, OP_CMN, OP_ORR, OP_MOV, OP_BIC, OP_MVN
        } alu_op_t;

        // The four barrel shifter kinds, plus a rotate for immediates.
        typedef enum logic [2:0] {
                SH_LSL,
                SH_LSR,
                SH_ASR,
                SH_ROR,
                SH_RORI
        } shift_op_t;

        // CPU modes in CPSR bits 4..0.
        localparam logic [4:0] MODE_USR = 5'b10000;
        localparam logic [4:0] MODE_FIQ = 5'b10001;
        localparam logic [4:0] MODE_IRQ = 5'b10010;
        localparam logic [4:0] MODE_SVC = 5'b10011;
        localparam logic [4:0] MODE_ABT = 5'b10111;
        localparam logic [4:0] MODE_UND = 5'b11011;
        localparam logic [4:0] MODE_SYS = 5'b11111;

        // Interrupt mask bits.
        localparam int CPSR_F = 6;
        localparam int CPSR_I = 7;

endpackage

`default_nettype wire

//--- decode_cfg_pkg.sv
`default_nettype none

package decode_cfg_pkg;

        localparam int ARCH_REGS = 16;
        localparam int PHY_REGS  = 32;

        typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
        typedef logic [$clog2(PHY_REGS)-1:0]  phy_idx_t;

        // Reads as zero, writes are dropped.
        localparam phy_idx_t RAZ_REGISTER = 5'd31;

        // Bit 32 set means bits 31..0 hold a literal, else a register index.
        typedef logic [32:0] operand_t;
        localparam int OPERAND_IMM = 32;

        localparam logic [31:0] PC_RESET_VALUE = 32'd8;

        // First physical register of each banked mode.
        localparam int FIQ_BANK_BASE = 16;
        localparam int IRQ_BANK_BASE = 23;
        localparam int SVC_BANK_BASE = 25;
        localparam int ABT_BANK_BASE = 27;
        localparam int UND_BANK_BASE = 29;

endpackage

`default_nettype wire

//--- decode_if.sv
`timescale 1ns/10ps
`default_nettype none

interface decode_if #(
        parameter int IDX_W = 4
);
        import arm_isa_pkg::*;
        import decode_cfg_pkg::*;

        cond_t            cond;
        alu_op_t          alu_op;
        operand_t         alu_src;
        operand_t         shift_src;
        shift_op_t        shift_op;
        operand_t         shift_len;
        logic [IDX_W-1:0] dest;
        logic             flag_update;
        logic [IDX_W-1:0] mem_srcdest;
        logic             mem_load;
        logic             mem_store;
        logic             mem_pre_index;
        logic             mem_ubyte;
        logic             mem_translate;
        logic             und;
        logic             swi;

        modport src (output cond, alu_op, alu_src, shift_src, shift_op, shift_len, dest,
                flag_update, mem_srcdest, mem_load, mem_store, mem_pre_index, mem_ubyte,
                mem_translate, und, swi);

        modport dst (input cond, alu_op, alu_src, shift_src, shift_op, shift_len, dest,
                flag_update, mem_srcdest, mem_load, mem_store, mem_pre_index, mem_ubyte,
                mem_translate, und, swi);

endinterface

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder
(
        input  wire [31:0] i_instruction,
        input  wire        i_instruction_valid,
        decode_if.src      o_bus
);
        import arm_isa_pkg::*;
        import decode_cfg_pkg::*;

        logic      is_dp;
        logic      is_ls;
        logic      is_swi;
        arch_idx_t rn;
        arch_idx_t rd;
        arch_idx_t rs;
        arch_idx_t rm;

        function automatic operand_t reg_op(input arch_idx_t r);
                return operand_t'(r);
        endfunction

        function automatic operand_t lit_op(input logic [31:0] v);
                return {1'b1, v};
        endfunction

        assign rn = i_instruction[19:16];
        assign rd = i_instruction[15:12];
        assign rs = i_instruction[11:8];
        assign rm = i_instruction[3:0];

        // Multiply and halfword encodings share the 00x space and are left out.
        assign is_dp  = i_instruction[27:26] == 2'b00 &&
                        !(!i_instruction[25] && i_instruction[7] && i_instruction[4]);
        assign is_ls  = i_instruction[27:26] == 2'b01 &&
                        !(i_instruction[25] && i_instruction[4]);
        assign is_swi = &i_instruction[27:24];

        always_comb
        begin
                o_bus.cond          = i_instruction_valid ? cond_t'(i_instruction[31:28]) : COND_NV;
                o_bus.alu_op        = OP_AND;
                o_bus.alu_src       = '0;
                o_bus.shift_src     = '0;
                o_bus.shift_op      = SH_LSL;
                o_bus.shift_len     = '0;
                o_bus.dest          = '0;
                o_bus.flag_update   = 1'b0;
                o_bus.mem_srcdest   = '0;
                o_bus.mem_load      = 1'b0;
                o_bus.mem_store     = 1'b0;
                o_bus.mem_pre_index = 1'b0;
                o_bus.mem_ubyte     = 1'b0;
                o_bus.mem_translate = 1'b0;
                o_bus.und           = i_instruction_valid && !(is_dp || is_ls || is_swi);
                o_bus.swi           = i_instruction_valid && is_swi;

                if (is_dp)
                begin
                        o_bus.alu_op      = alu_op_t'(i_instruction[24:21]);
                        o_bus.alu_src     = reg_op(rn);
                        o_bus.flag_update = i_instruction[20];
                        // TST, TEQ, CMP and CMN only set flags.
                        o_bus.dest        = (i_instruction[24:23] == 2'b10) ?
                                            RAZ_REGISTER : phy_idx_t'(rd);
                        if (i_instruction[25])
                        begin
                                o_bus.shift_src = lit_op({24'd0, i_instruction[7:0]});
                                o_bus.shift_len = lit_op({27'd0, i_instruction[11:8], 1'b0});
                                o_bus.shift_op  = SH_RORI;
                        end
                        else
                        begin
                                o_bus.shift_src = reg_op(rm);
                                o_bus.shift_len = i_instruction[4] ? reg_op(rs) :
                                                  lit_op({27'd0, i_instruction[11:7]});
                                o_bus.shift_op  = shift_op_t'({1'b0, i_instruction[6:5]});
                        end
                end
                else if (is_ls)
                begin
                        o_bus.alu_op        = i_instruction[23] ? OP_ADD : OP_SUB;
                        o_bus.alu_src       = reg_op(rn);
                        o_bus.shift_src     = lit_op({20'd0, i_instruction[11:0]});
                        o_bus.shift_len     = lit_op(32'd0);
                        if (i_instruction[25])
                        begin
                                o_bus.shift_src = reg_op(rm);
                                o_bus.shift_len = lit_op({27'd0, i_instruction[11:7]});
                                o_bus.shift_op  = shift_op_t'({1'b0, i_instruction[6:5]});
                        end
                        o_bus.mem_srcdest   = phy_idx_t'(rd);
                        o_bus.mem_load      = i_instruction[20];
                        o_bus.mem_store     = !i_instruction[20];
                        o_bus.mem_pre_index = i_instruction[24];
                        o_bus.mem_ubyte     = i_instruction[22];
                        // Post-index with W forces a user-mode access.
                        o_bus.mem_translate = !i_instruction[24] && i_instruction[21];
                        // Base writeback goes to Rn, else the result is dropped.
                        o_bus.dest          = (!i_instruction[24] || i_instruction[21]) ?
                                              phy_idx_t'(rn) : RAZ_REGISTER;
                end
        end

endmodule

`default_nettype wire

//--- reg_index_translator.sv
`timescale 1ns/10ps
`default_nettype none

module reg_index_translator #(
        parameter int ARCH_REGS = decode_cfg_pkg::ARCH_REGS,
        parameter int PHY_REGS  = decode_cfg_pkg::PHY_REGS
)
(
        input  wire [4:0] i_cpu_mode,
        decode_if.dst     i_arch,
        decode_if.src     o_phys
);
        import arm_isa_pkg::*;
        import decode_cfg_pkg::*;

        function automatic phy_idx_t map_index(input phy_idx_t idx, input logic [4:0] mode);
                arch_idx_t r;
                int        base;
                r = arch_idx_t'(idx);
                case (mode)
                MODE_IRQ: base = IRQ_BANK_BASE;
                MODE_SVC: base = SVC_BANK_BASE;
                MODE_ABT: base = ABT_BANK_BASE;
                MODE_UND: base = UND_BANK_BASE;
                default:  base = 0;
                endcase
                // RAZ and other non-architectural indices are left alone.
                if (int'(idx) >= ARCH_REGS)
                        return idx;
                else if (mode == MODE_FIQ && r >= 8 && r <= 14)
                        return phy_idx_t'(FIQ_BANK_BASE + int'(r) - 8);
                else if (base != 0 && r >= 13 && r <= 14)
                        return phy_idx_t'(base + int'(r) - 13);
                else
                        return idx;
        endfunction

        function automatic operand_t map_operand(input operand_t op, input logic [4:0] mode);
                if (op[OPERAND_IMM])
                        return op;
                return operand_t'(map_index(phy_idx_t'(op), mode));
        endfunction

        function automatic logic op_in_range(input operand_t op);
                return op[OPERAND_IMM] || op[31:0] < PHY_REGS;
        endfunction

        assign o_phys.cond          = i_arch.cond;
        assign o_phys.alu_op        = i_arch.alu_op;
        assign o_phys.alu_src       = map_operand(i_arch.alu_src, i_cpu_mode);
        assign o_phys.shift_src     = map_operand(i_arch.shift_src, i_cpu_mode);
        assign o_phys.shift_op      = i_arch.shift_op;
        assign o_phys.shift_len     = map_operand(i_arch.shift_len, i_cpu_mode);
        assign o_phys.dest          = map_index(i_arch.dest, i_cpu_mode);
        assign o_phys.flag_update   = i_arch.flag_update;
        assign o_phys.mem_srcdest   = map_index(i_arch.mem_srcdest, i_cpu_mode);
        assign o_phys.mem_load      = i_arch.mem_load;
        assign o_phys.mem_store     = i_arch.mem_store;
        assign o_phys.mem_pre_index = i_arch.mem_pre_index;
        assign o_phys.mem_ubyte     = i_arch.mem_ubyte;
        assign o_phys.mem_translate = i_arch.mem_translate;
        assign o_phys.und           = i_arch.und;
        assign o_phys.swi           = i_arch.swi;

        idx_range: assert final (o_phys.dest < PHY_REGS && o_phys.mem_srcdest < PHY_REGS &&
                op_in_range(o_phys.alu_src) && op_in_range(o_phys.shift_src) &&
                op_in_range(o_phys.shift_len));

endmodule

`default_nettype wire

//--- decode_output_reg.sv
`timescale 1ns/10ps
`default_nettype none

module decode_output_reg
(
        input  wire                         i_clk,
        input  wire                         i_reset,
        input  wire                         i_clear_from_writeback,
        input  wire                         i_data_stall,
        input  wire                         i_clear_from_alu,
        input  wire                         i_stall_from_shifter,
        input  wire                         i_stall_from_issue,
        input  wire                         i_irq,
        input  wire                         i_fiq,
        input  wire                         i_abt,
        input  wire [31:0]                  i_cpsr,
        input  wire [31:0]                  i_pc_plus_8,
        decode_if.dst                       i_phys,
        output arm_isa_pkg::cond_t          o_condition_code_ff,
        output decode_cfg_pkg::phy_idx_t    o_destination_index_ff,
        output decode_cfg_pkg::operand_t    o_alu_source_ff,
        output arm_isa_pkg::alu_op_t        o_alu_operation_ff,
        output decode_cfg_pkg::operand_t    o_shift_source_ff,
        output arm_isa_pkg::shift_op_t      o_shift_operation_ff,
        output decode_cfg_pkg::operand_t    o_shift_length_ff,
        output logic                        o_flag_update_ff,
        output decode_cfg_pkg::phy_idx_t    o_mem_srcdest_index_ff,
        output logic                        o_mem_load_ff,
        output logic                        o_mem_store_ff,
        output logic                        o_mem_pre_index_ff,
        output logic                        o_mem_unsigned_byte_enable_ff,
        output logic                        o_mem_translate_ff,
        output logic [31:0]                 o_pc_plus_8_ff,
        output logic                        o_irq_ff,
        output logic                        o_fiq_ff,
        output logic                        o_abt_ff,
        output logic                        o_und_ff,
        output logic                        o_swi_ff
);
        import arm_isa_pkg::*;
        import decode_cfg_pkg::*;

        logic do_clear;
        logic do_hold;

        // The data stall outranks the ALU clear, the writeback clear outranks both.
        assign do_clear = i_reset || i_clear_from_writeback ||
                          (!i_data_stall && i_clear_from_alu);
        assign do_hold  = i_data_stall || i_stall_from_shifter || i_stall_from_issue;

        always_ff @(posedge i_clk)
        begin
                if (do_clear)
                begin
                        o_condition_code_ff           <= COND_NV;
                        o_destination_index_ff        <= '0;
                        o_alu_source_ff               <= '0;
                        o_alu_operation_ff            <= OP_AND;
                        o_shift_source_ff             <= '0;
                        o_shift_operation_ff          <= SH_LSL;
                        o_shift_length_ff             <= '0;
                        o_flag_update_ff              <= 1'b0;
                        o_mem_srcdest_index_ff        <= RAZ_REGISTER;
                        o_mem_load_ff                 <= 1'b0;
                        o_mem_store_ff                <= 1'b0;
                        o_mem_pre_index_ff            <= 1'b0;
                        o_mem_unsigned_byte_enable_ff <= 1'b0;
                        o_mem_translate_ff            <= 1'b0;
                        o_pc_plus_8_ff                <= PC_RESET_VALUE;
                        o_irq_ff                      <= 1'b0;
                        o_fiq_ff                      <= 1'b0;
                        o_abt_ff                      <= 1'b0;
                        o_und_ff                      <= 1'b0;
                        o_swi_ff                      <= 1'b0;
                end
                else if (!do_hold)
                begin
                        o_condition_code_ff           <= i_phys.cond;
                        o_destination_index_ff        <= i_phys.dest;
                        o_alu_source_ff               <= i_phys.alu_src;
                        o_alu_operation_ff            <= i_phys.alu_op;
                        o_shift_source_ff             <= i_phys.shift_src;
                        o_shift_operation_ff          <= i_phys.shift_op;
                        o_shift_length_ff             <= i_phys.shift_len;
                        o_flag_update_ff              <= i_phys.flag_update;
                        o_mem_srcdest_index_ff        <= i_phys.mem_srcdest;
                        o_mem_load_ff                 <= i_phys.mem_load;
                        o_mem_store_ff                <= i_phys.mem_store;
                        o_mem_pre_index_ff            <= i_phys.mem_pre_index;
                        o_mem_unsigned_byte_enable_ff <= i_phys.mem_ubyte;
                        o_mem_translate_ff            <= i_phys.mem_translate;
                        o_pc_plus_8_ff                <= i_pc_plus_8;
                        // A set mask bit blocks the interrupt.
                        o_irq_ff                      <= i_irq && !i_cpsr[CPSR_I];
                        o_fiq_ff                      <= i_fiq && !i_cpsr[CPSR_F];
                        o_abt_ff                      <= i_abt;
                        o_und_ff                      <= i_phys.und;
                        o_swi_ff                      <= i_phys.swi;
                end
        end

        clear_to_nv: assert property (@(posedge i_clk)
                do_clear |=> o_condition_code_ff == COND_NV);

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage #(
        parameter int ARCH_REGS = decode_cfg_pkg::ARCH_REGS,
        parameter int PHY_REGS  = decode_cfg_pkg::PHY_REGS
)
(
        input  wire                         i_clk,
        input  wire                         i_reset,
        input  wire                         i_clear_from_writeback,
        input  wire                         i_data_stall,
        input  wire                         i_clear_from_alu,
        input  wire                         i_stall_from_shifter,
        input  wire                         i_stall_from_issue,
        input  wire                         i_irq,
        input  wire                         i_fiq,
        input  wire                         i_abt,
        input  wire [31:0]                  i_pc_plus_8,
        input  wire [31:0]                  i_cpu_mode,
        input  wire [31:0]                  i_instruction,
        input  wire                         i_instruction_valid,
        output wire arm_isa_pkg::cond_t     o_condition_code_ff,
        output wire decode_cfg_pkg::phy_idx_t o_destination_index_ff,
        output wire decode_cfg_pkg::operand_t o_alu_source_ff,
        output wire arm_isa_pkg::alu_op_t   o_alu_operation_ff,
        output wire decode_cfg_pkg::operand_t o_shift_source_ff,
        output wire arm_isa_pkg::shift_op_t o_shift_operation_ff,
        output wire decode_cfg_pkg::operand_t o_shift_length_ff,
        output wire                         o_flag_update_ff,
        output wire decode_cfg_pkg::phy_idx_t o_mem_srcdest_index_ff,
        output wire                         o_mem_load_ff,
        output wire                         o_mem_store_ff,
        output wire                         o_mem_pre_index_ff,
        output wire                         o_mem_unsigned_byte_enable_ff,
        output wire                         o_mem_translate_ff,
        output wire [31:0]                  o_pc_plus_8_ff,
        output wire                         o_irq_ff,
        output wire                         o_fiq_ff,
        output wire                         o_abt_ff,
        output wire                         o_und_ff,
        output wire                         o_swi_ff
);

        // Both buses carry indices at physical width so the RAZ index survives decode.
        decode_if #(.IDX_W($clog2(PHY_REGS))) arch_bus ();
        decode_if #(.IDX_W($clog2(PHY_REGS))) phys_bus ();

        instr_decoder instr_decoder_inst (
                .i_instruction       (i_instruction),
                .i_instruction_valid (i_instruction_valid),
                .o_bus               (arch_bus)
        );

        reg_index_translator #(
                .ARCH_REGS (ARCH_REGS),
                .PHY_REGS  (PHY_REGS)
        ) reg_index_translator_inst (
                .i_cpu_mode (i_cpu_mode[4:0]),
                .i_arch     (arch_bus),
                .o_phys     (phys_bus)
        );

        // The remaining ports share their names with the top level.
        decode_output_reg decode_output_reg_inst (
                .i_cpsr (i_cpu_mode),
                .i_phys (phys_bus),
                .*
        );

endmodule

`default_nettype wire

//--- tb_decode_checks.svh
// Inputs change 1 ns after the rising edge, and outputs are sampled at that point too.
task automatic next_cycle();
        @(posedge i_clk);
        #1;
endtask

task automatic drive(input logic [31:0] instr, input logic [31:0] cpsr, input logic [31:0] pc);
        i_instruction       = instr;
        i_instruction_valid = 1'b1;
        i_cpu_mode          = cpsr;
        i_pc_plus_8         = pc;
endtask

// Bit order is writeback clear, data stall, ALU clear, shifter stall, issue stall.
task automatic set_ctrl(input logic [4:0] c);
        {i_clear_from_writeback, i_data_stall, i_clear_from_alu,
         i_stall_from_shifter, i_stall_from_issue} = c;
endtask

task automatic report_mismatch(input string name, input logic [32:0] got,
                               input logic [32:0] exp);
        errors++;
        $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
endtask

task automatic check_cond(input string name, input cond_t got, input cond_t exp);
        if (got !== exp)
                report_mismatch(name, got, exp);
endtask

task automatic check_idx(input string name, input phy_idx_t got, input phy_idx_t exp);
        if (got !== exp)
                report_mismatch(name, got, exp);
endtask

task automatic check_operand(input string name, input operand_t got, input operand_t exp);
        if (got !== exp)
                report_mismatch(name, got, exp);
endtask

task automatic check_alu_op(input string name, input alu_op_t got, input alu_op_t exp);
        if (got !== exp)
                report_mismatch(name, got, exp);
endtask

task automatic check_shift_op(input string name, input shift_op_t got, input shift_op_t exp);
        if (got !== exp)
                report_mismatch(name, got, exp);
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
                report_mismatch(name, got, exp);
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
                report_mismatch(name, got, exp);
endtask

function automatic operand_t as_reg(input phy_idx_t idx);
        return {28'd0, idx};
endfunction

function automatic operand_t as_lit(input logic [31:0] v);
        return {1'b1, v};
endfunction

// Expected physical index from the banking table.
function automatic phy_idx_t banked_index(input int r, input logic [4:0] mode);
        case (mode)
        MODE_FIQ: return phy_idx_t'((r >= 8 && r <= 14) ? r + 8 : r);
        MODE_IRQ: return phy_idx_t'((r >= 13 && r <= 14) ? r + 10 : r);
        MODE_SVC: return phy_idx_t'((r >= 13 && r <= 14) ? r + 12 : r);
        MODE_ABT: return phy_idx_t'((r >= 13 && r <= 14) ? r + 14 : r);
        MODE_UND: return phy_idx_t'((r >= 13 && r <= 14) ? r + 16 : r);
        default:  return phy_idx_t'(r);
        endcase
endfunction

task automatic check_datapath(input alu_op_t op, input operand_t src, input operand_t sh_src,
                              input operand_t sh_len, input shift_op_t sh_op,
                              input phy_idx_t dest);
        check_alu_op("o_alu_operation_ff", o_alu_operation_ff, op);
        check_operand("o_alu_source_ff", o_alu_source_ff, src);
        check_operand("o_shift_source_ff", o_shift_source_ff, sh_src);
        check_operand("o_shift_length_ff", o_shift_length_ff, sh_len);
        check_shift_op("o_shift_operation_ff", o_shift_operation_ff, sh_op);
        check_idx("o_destination_index_ff", o_destination_index_ff, dest);
endtask

task automatic check_mem(input logic load, input logic pre, input logic ubyte,
                         input logic trans, input phy_idx_t srcdest);
        check_bit("o_mem_load_ff", o_mem_load_ff, load);
        check_bit("o_mem_store_ff", o_mem_store_ff, !load);
        check_bit("o_mem_pre_index_ff", o_mem_pre_index_ff, pre);
        check_bit("o_mem_unsigned_byte_enable_ff", o_mem_unsigned_byte_enable_ff, ubyte);
        check_bit("o_mem_translate_ff", o_mem_translate_ff, trans);
        check_idx("o_mem_srcdest_index_ff", o_mem_srcdest_index_ff, srcdest);
endtask

task automatic check_state(input cond_t cond, input phy_idx_t dest, input logic [31:0] pc);
        check_cond("o_condition_code_ff", o_condition_code_ff, cond);
        check_idx("o_destination_index_ff", o_destination_index_ff, dest);
        check_word("o_pc_plus_8_ff", o_pc_plus_8_ff, pc);
endtask

task automatic check_cleared();
        check_state(COND_NV, 5'd0, 32'd8);
        check_idx("o_mem_srcdest_index_ff", o_mem_srcdest_index_ff, RAZ_REGISTER);
        check_bit("o_und_ff", o_und_ff, 1'b0);
endtask

task automatic test_data_processing();
        arch_idx_t  rn, rd, rs, rm;
        logic [3:0] rot;
        logic [7:0] imm;
        {rn, rd, rs, rm} = 16'($urandom);
        {rot, imm}       = 12'($urandom);
        // ADD rd, rn, rm, ASR rs.
        drive({4'hE, 8'h08, rn, rd, rs, 4'b0101, rm}, USR_CPSR, 32'h100);
        next_cycle();
        check_cond("o_condition_code_ff", o_condition_code_ff, COND_AL);
        check_datapath(OP_ADD, as_reg(rn), as_reg(rm), as_reg(rs), SH_ASR, rd);
        check_bit("o_flag_update_ff", o_flag_update_ff, 1'b0);
        // CMPS rn, #imm ror twice rot.
        drive({4'hE, 8'h35, rn, 4'd0, rot, imm}, USR_CPSR, 32'h104);
        next_cycle();
        check_datapath(OP_CMP, as_reg(rn), as_lit(32'(imm)), as_lit(2 * 32'(rot)), SH_RORI,
                       RAZ_REGISTER);
        check_bit("o_flag_update_ff", o_flag_update_ff, 1'b1);
endtask

task automatic test_banking();
        logic [4:0] modes [7];
        logic [4:0] m;
        modes = '{MODE_USR, MODE_FIQ, MODE_IRQ, MODE_SVC, MODE_ABT, MODE_UND, MODE_SYS};
        foreach (modes[i])
        begin
                m = modes[i];
                // ADD r14, r13, r8, LSL r14.
                drive({4'hE, 8'h08, 4'd13, 4'd14, 4'd14, 4'b0001, 4'd8}, {27'd0, m}, 32'h200);
                next_cycle();
                check_datapath(OP_ADD, as_reg(banked_index(13, m)), as_reg(banked_index(8, m)),
                               as_reg(banked_index(14, m)), SH_LSL, banked_index(14, m));
                // ADD r13, r8, #0x5A ror 4.
                drive({4'hE, 8'h28, 4'd8, 4'd13, 4'd2, 8'h5A}, {27'd0, m}, 32'h204);
                next_cycle();
                check_datapath(OP_ADD, as_reg(banked_index(8, m)), as_lit(32'h5A),
                               as_lit(32'd4), SH_RORI, banked_index(13, m));
        end
endtask

task automatic test_load_store();
        arch_idx_t   rn, rd, rm;
        logic [11:0] imm;
        {rn, rd, rm} = 12'($urandom);
        imm          = 12'($urandom);
        // LDR rd, [rn, #imm]! writes the base back.
        drive({4'hE, 8'h5B, rn, rd, imm}, USR_CPSR, 32'h300);
        next_cycle();
        check_datapath(OP_ADD, as_reg(rn), as_lit(32'(imm)), as_lit(32'd0), SH_LSL, rn);
        check_mem(1'b1, 1'b1, 1'b0, 1'b0, rd);
        // STRB rd, [rn, #-imm] leaves the base alone.
        drive({4'hE, 8'h54, rn, rd, imm}, USR_CPSR, 32'h304);
        next_cycle();
        check_datapath(OP_SUB, as_reg(rn), as_lit(32'(imm)), as_lit(32'd0), SH_LSL,
                       RAZ_REGISTER);
        check_mem(1'b0, 1'b1, 1'b1, 1'b0, rd);
        // LDRT rd, [rn], rm, LSR #5.
        drive({4'hE, 8'h6B, rn, rd, 5'd5, 2'b01, 1'b0, rm}, USR_CPSR, 32'h308);
        next_cycle();
        check_datapath(OP_ADD, as_reg(rn), as_reg(rm), as_lit(32'd5), SH_LSR, rn);
        check_mem(1'b1, 1'b0, 1'b0, 1'b1, rd);
endtask

task automatic test_swi_und();
        drive({4'hE, 4'hF, 24'h000042}, USR_CPSR, 32'h400);
        next_cycle();
        check_bit("o_swi_ff", o_swi_ff, 1'b1);
        check_bit("o_und_ff", o_und_ff, 1'b0);
        // Branches are not decoded here.
        drive({4'hE, 4'hA, 24'h000010}, USR_CPSR, 32'h404);
        next_cycle();
        check_bit("o_und_ff", o_und_ff, 1'b1);
        check_bit("o_swi_ff", o_swi_ff, 1'b0);
        drive({4'hE, 4'hA, 24'h000010}, USR_CPSR, 32'h408);
        i_instruction_valid = 1'b0;
        next_cycle();
        check_cond("o_condition_code_ff", o_condition_code_ff, COND_NV);
        check_bit("o_und_ff", o_und_ff, 1'b0);
endtask

task automatic test_interrupts();
        logic [1:0] mask;
        {i_irq, i_fiq, i_abt} = 3'b111;
        for (int n = 0; n < 4; n++)
        begin
                mask = 2'(n);
                // CPSR bit 7 is I and bit 6 is F.
                drive({4'hE, 8'h08, 20'd0}, {24'd0, mask, 1'b0, MODE_USR}, 32'h500);
                next_cycle();
                check_bit("o_irq_ff", o_irq_ff, !mask[1]);
                check_bit("o_fiq_ff", o_fiq_ff, !mask[0]);
                check_bit("o_abt_ff", o_abt_ff, 1'b1);
        end
        {i_irq, i_fiq, i_abt} = 3'b000;
        // With the inputs low and no mask set, nothing is flagged.
        drive({4'hE, 8'h08, 20'd0}, USR_CPSR, 32'h504);
        next_cycle();
        check_bit("o_irq_ff", o_irq_ff, 1'b0);
        check_bit("o_fiq_ff", o_fiq_ff, 1'b0);
        check_bit("o_abt_ff", o_abt_ff, 1'b0);
endtask

task automatic test_priority();
        logic [31:0] instr_a;
        logic [31:0] instr_b;
        logic [4:0]  holds [3];
        holds   = '{5'b01000, 5'b00010, 5'b00001};
        // ADD r1, r2, r3 and ADDEQ r5, r2, r3.
        instr_a = {4'hE, 8'h08, 4'd2, 4'd1, 8'd0, 4'd3};
        instr_b = {4'h0, 8'h08, 4'd2, 4'd5, 8'd0, 4'd3};
        drive(instr_a, USR_CPSR, 32'h600);
        next_cycle();
        drive(instr_b, USR_CPSR, 32'h604);
        foreach (holds[h])
        begin
                set_ctrl(holds[h]);
                next_cycle();
                check_state(COND_AL, 5'd1, 32'h600);
        end
        set_ctrl(5'b00000);
        next_cycle();
        check_state(cond_t'(4'h0), 5'd5, 32'h604);
        // Data stall outranks the ALU clear.
        drive(instr_a, USR_CPSR, 32'h608);
        set_ctrl(5'b01100);
        next_cycle();
        check_state(cond_t'(4'h0), 5'd5, 32'h604);
        // Writeback clear outranks the data stall.
        set_ctrl(5'b11000);
        next_cycle();
        check_cleared();
        set_ctrl(5'b00000);
        next_cycle();
        check_state(COND_AL, 5'd1, 32'h608);
        set_ctrl(5'b00100);
        next_cycle();
        check_cleared();
        set_ctrl(5'b00000);
endtask

//--- tb_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;
        import arm_isa_pkg::*;
        import decode_cfg_pkg::*;

        localparam logic [31:0] USR_CPSR = {27'd0, MODE_USR};

        logic        i_clk;
        logic        i_reset;
        logic        i_clear_from_writeback, i_data_stall, i_clear_from_alu;
        logic        i_stall_from_shifter, i_stall_from_issue;
        logic        i_irq, i_fiq, i_abt;
        logic [31:0] i_pc_plus_8, i_cpu_mode, i_instruction;
        logic        i_instruction_valid;
        cond_t       o_condition_code_ff;
        phy_idx_t    o_destination_index_ff, o_mem_srcdest_index_ff;
        operand_t    o_alu_source_ff, o_shift_source_ff, o_shift_length_ff;
        alu_op_t     o_alu_operation_ff;
        shift_op_t   o_shift_operation_ff;
        logic        o_flag_update_ff, o_mem_load_ff, o_mem_store_ff, o_mem_pre_index_ff;
        logic        o_mem_unsigned_byte_enable_ff, o_mem_translate_ff;
        logic [31:0] o_pc_plus_8_ff;
        logic        o_irq_ff, o_fiq_ff, o_abt_ff, o_und_ff, o_swi_ff;
        int          errors;
        int unsigned seed;

        decode_stage decode_stage_inst (.*);

        initial
                i_clk = 1'b0;

        // 10 ns period.
        always #5 i_clk = !i_clk;

        `include "tb_decode_checks.svh"

        initial
        begin
                errors = 0;
                seed   = 32'h977a3234;
                void'($urandom(seed));
                i_reset = 1'b1;
                set_ctrl(5'b00000);
                {i_irq, i_fiq, i_abt} = 3'b000;
                drive(32'd0, USR_CPSR, 32'd0);
                for (int n = 0; n < 5; n++)
                        next_cycle();
                i_reset = 1'b0;
                check_cleared();

                test_data_processing();
                test_banking();
                test_load_store();
                test_swi_und();
                test_interrupts();
                test_priority();

                $display("Finished with %0d errors", errors);
                if (errors == 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
arm_isa_pkg.sv
decode_cfg_pkg.sv
decode_if.sv
instr_decoder.sv
reg_index_translator.sv
decode_output_reg.sv
decode_stage.sv
tb_decode_stage.sv

//--- Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - .

sources:
  - arm_isa_pkg.sv
  - decode_cfg_pkg.sv
  - decode_if.sv
  - instr_decoder.sv
  - reg_index_translator.sv
  - decode_output_reg.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_decode_stage.sv
